/* hw/letc_core_params.svh */
`ifndef LETC_CORE_PARAMS_SVH
`define LETC_CORE_PARAMS_SVH

// Data word width
`define LETC_CORE_XLEN 32

// Architectural integer registers
`define LETC_CORE_NUM_REGS 32

// Major opcodes handled by this pipeline
`define LETC_CORE_OPCODE_OP     7'b0110011
`define LETC_CORE_OPCODE_OP_IMM 7'b0010011
// Load upper immediate
`define LETC_CORE_OPCODE_LUI    7'b0110111

`endif

/* hw/letc_core_pkg.sv */
`default_nettype none

`include "letc_core_params.svh"

package letc_core_pkg;

    // Basic widths
    typedef logic [`LETC_CORE_XLEN-1:0] word_t;
    typedef logic [31:0] instr_t;
    typedef logic [$clog2(`LETC_CORE_NUM_REGS)-1:0] reg_idx_t;

    // funct3 with instruction bit 30 on top
    typedef logic [3:0] alu_op_t;

    // Decode to execute
    typedef struct packed {
        logic     valid;
        logic     illegal;
        reg_idx_t rd_idx;
        logic     rd_we;
        alu_op_t  alu_op;
        // Already bypassed with the immediate already muxed in
        word_t    op_a;
        word_t    op_b;
    } d_to_e_s;

    // Execute result and write-back register contents
    typedef struct packed {
        logic     valid;
        logic     illegal;
        reg_idx_t rd_idx;
        logic     rd_we;
        word_t    result;
    } e_to_w_s;

    // Retire record seen outside the core
    typedef struct packed {
        logic     valid;
        logic     illegal;
        reg_idx_t rd_idx;
        word_t    value;
    } retire_s;

endpackage : letc_core_pkg

`default_nettype wire

/* hw/letc_core_rf.sv */
`timescale 1ns/1ps
`default_nettype none

`include "letc_core_params.svh"

module letc_core_rf (
    input  logic                    clk,
    input  logic                    reset,

    // Read ports
    input  letc_core_pkg::reg_idx_t rs1_idx,
    input  letc_core_pkg::reg_idx_t rs2_idx,
    output letc_core_pkg::word_t    rs1_val,
    output letc_core_pkg::word_t    rs2_val,

    // Write port
    input  letc_core_pkg::reg_idx_t rd_idx,
    input  letc_core_pkg::word_t    rd_val,
    input  logic                    rd_wen
);
    import letc_core_pkg::*;

    // Architectural state including the never written x0
    word_t regs [0:`LETC_CORE_NUM_REGS-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `LETC_CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && (rd_idx != '0)) begin
            regs[rd_idx] <= rd_val;
        end
    end

    // Asynchronous reads with x0 hardwired to zero
    assign rs1_val = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule : letc_core_rf

`default_nettype wire

/* hw/letc_core_stage_d.sv */
`timescale 1ns/1ps
`default_nettype none

`include "letc_core_params.svh"

module letc_core_stage_d (
    input  logic                    clk,
    input  logic                    reset,

    // Incoming instruction strobe
    input  logic                    instr_valid,
    input  letc_core_pkg::instr_t   instr,

    // Register file read ports
    output letc_core_pkg::reg_idx_t rs1_idx,
    output letc_core_pkg::reg_idx_t rs2_idx,
    input  letc_core_pkg::word_t    rs1_val,
    input  letc_core_pkg::word_t    rs2_val,

    // Bypass sources with the youngest first
    input  letc_core_pkg::e_to_w_s  e_result,
    input  letc_core_pkg::e_to_w_s  e_to_w,

    // To E
    output letc_core_pkg::d_to_e_s  d_to_e
);
    import letc_core_pkg::*;

    // Captured instruction
    logic       instr_valid_q;
    instr_t     instr_q;

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    reg_idx_t   rd_field;
    word_t      imm_i;
    word_t      imm_u;

    // Opcode class
    logic       is_op;
    logic       is_op_imm;
    logic       is_lui;
    logic       legal;

    // Operands after bypass
    word_t      rs1_byp;
    word_t      rs2_byp;
    d_to_e_s    d_next;

    // E result beats W result and W beats the register file
    function automatic word_t bypass_operand(input reg_idx_t idx, input word_t rf_val);
        if (idx == '0) begin
            return '0;
        end else if (e_result.valid && e_result.rd_we && (e_result.rd_idx == idx)) begin
            return e_result.result;
        end else if (e_to_w.valid && e_to_w.rd_we && (e_to_w.rd_idx == idx)) begin
            return e_to_w.result;
        end
        return rf_val;
    endfunction

    // Input sample register
    always_ff @(posedge clk) begin
        instr_q <= instr;
        if (reset) begin
            instr_valid_q <= 1'b0;
        end else begin
            instr_valid_q <= instr_valid;
        end
    end

    // Field split
    assign opcode   = instr_q[6:0];
    assign rd_field = instr_q[11:7];
    assign funct3   = instr_q[14:12];
    assign rs1_idx  = instr_q[19:15];
    assign rs2_idx  = instr_q[24:20];
    assign imm_i    = {{(`LETC_CORE_XLEN-12){instr_q[31]}}, instr_q[31:20]};
    assign imm_u    = {instr_q[31:12], 12'b0};

    assign is_op     = (opcode == `LETC_CORE_OPCODE_OP);
    assign is_op_imm = (opcode == `LETC_CORE_OPCODE_OP_IMM);
    assign is_lui    = (opcode == `LETC_CORE_OPCODE_LUI);
    assign legal     = is_op | is_op_imm | is_lui;

    always_comb begin
        rs1_byp = bypass_operand(rs1_idx, rs1_val);
        rs2_byp = bypass_operand(rs2_idx, rs2_val);
    end

    always_comb begin
        d_next         = '0;
        d_next.valid   = instr_valid_q;
        d_next.illegal = instr_valid_q & ~legal;
        d_next.rd_idx  = rd_field;
        // Illegal words never write
        d_next.rd_we   = instr_valid_q & legal;
        d_next.op_a    = rs1_byp;
        d_next.op_b    = rs2_byp;
        if (is_op) begin
            d_next.alu_op = {instr_q[30], funct3};
        end else if (is_op_imm) begin
            // Bit 30 is an immediate bit except for srai
            d_next.alu_op = {(funct3 == 3'b101) & instr_q[30], funct3};
            d_next.op_b   = imm_i;
        end else if (is_lui) begin
            // 0 + upper immediate through the adder
            d_next.alu_op = 4'b0000;
            d_next.op_a   = '0;
            d_next.op_b   = imm_u;
        end
    end

    always_ff @(posedge clk) begin
        d_to_e <= d_next;
        if (reset) begin
            d_to_e.valid   <= 1'b0;
            d_to_e.illegal <= 1'b0;
            d_to_e.rd_we   <= 1'b0;
        end
    end

endmodule : letc_core_stage_d

`default_nettype wire

/* hw/letc_core_stage_e.sv */
`timescale 1ns/1ps
`default_nettype none

`include "letc_core_params.svh"

module letc_core_stage_e (
    // From D
    input  letc_core_pkg::d_to_e_s d_to_e,

    // To W and to the D bypass
    output letc_core_pkg::e_to_w_s e_result
);
    import letc_core_pkg::*;

    // Shifts use the low bits of op_b only
    localparam int SHAMT_W = $clog2(`LETC_CORE_XLEN);

    alu_op_t            alu_op;
    word_t              op_a;
    word_t              op_b;
    logic [SHAMT_W-1:0] shamt;
    // Bit 30 selects sub over add and sra over srl
    logic               alt;
    logic               lt_signed;
    logic               lt_unsigned;
    word_t              alu_out;

    assign alu_op = d_to_e.alu_op;
    assign op_a   = d_to_e.op_a;
    assign op_b   = d_to_e.op_b;
    assign shamt  = op_b[SHAMT_W-1:0];
    assign alt    = alu_op[3];

    assign lt_signed   = $signed(op_a) < $signed(op_b);
    assign lt_unsigned = op_a < op_b;

    // Selected by funct3
    always_comb begin
        unique case (alu_op[2:0])
            3'b000: begin
                alu_out = alt ? (op_a - op_b) : (op_a + op_b);
            end
            3'b001: begin
                alu_out = op_a << shamt;
            end
            3'b010: begin
                alu_out = word_t'(lt_signed);
            end
            3'b011: begin
                alu_out = word_t'(lt_unsigned);
            end
            3'b100: begin
                alu_out = op_a ^ op_b;
            end
            3'b101: begin
                // Arithmetic shift keeps the sign of op_a
                alu_out = alt ? word_t'($signed(op_a) >>> shamt) : (op_a >> shamt);
            end
            3'b110: begin
                alu_out = op_a | op_b;
            end
            default: begin
                alu_out = op_a & op_b;
            end
        endcase
    end

    // Control fields pass straight through
    assign e_result.valid   = d_to_e.valid;
    assign e_result.illegal = d_to_e.illegal;
    assign e_result.rd_idx  = d_to_e.rd_idx;
    assign e_result.rd_we   = d_to_e.rd_we;
    assign e_result.result  = alu_out;

endmodule : letc_core_stage_e

`default_nettype wire

/* hw/letc_core_stage_w.sv */
`timescale 1ns/1ps
`default_nettype none

module letc_core_stage_w (
    input  logic                    clk,
    input  logic                    reset,

    // From E
    input  letc_core_pkg::e_to_w_s  e_result,

    // Registered result that also feeds the D bypass
    output letc_core_pkg::e_to_w_s  e_to_w,

    // Register file write port
    output letc_core_pkg::reg_idx_t rd_idx,
    output letc_core_pkg::word_t    rd_val,
    output logic                    rd_wen,

    // Retire record
    output letc_core_pkg::retire_s  retire
);

    always_ff @(posedge clk) begin
        e_to_w <= e_result;
        if (reset) begin
            e_to_w.valid   <= 1'b0;
            e_to_w.illegal <= 1'b0;
            e_to_w.rd_we   <= 1'b0;
        end
    end

    // x0 writes still retire but never reach the RF
    assign rd_idx = e_to_w.rd_idx;
    assign rd_val = e_to_w.result;
    assign rd_wen = e_to_w.valid & e_to_w.rd_we & (e_to_w.rd_idx != '0);

    assign retire.valid   = e_to_w.valid;
    assign retire.illegal = e_to_w.illegal;
    assign retire.rd_idx  = e_to_w.rd_idx;
    assign retire.value   = e_to_w.result;

endmodule : letc_core_stage_w

`default_nettype wire

/* hw/letc_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module letc_core_top (
    input  logic                   clk,
    input  logic                   reset,

    // Instruction in, one per strobe
    input  logic                   instr_valid,
    input  letc_core_pkg::instr_t  instr,

    // Retire out
    output letc_core_pkg::retire_s retire
);
    import letc_core_pkg::*;

    // rs1/rs2 read ports
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_val;
    word_t    rs2_val;

    // rd write port
    reg_idx_t rd_idx;
    word_t    rd_val;
    logic     rd_wen;

    // Inter-stage packets
    d_to_e_s  d_to_e;
    e_to_w_s  e_result;
    e_to_w_s  e_to_w;

    letc_core_rf rf (
        .clk     (clk),
        .reset   (reset),
        .rs1_idx (rs1_idx),
        .rs2_idx (rs2_idx),
        .rs1_val (rs1_val),
        .rs2_val (rs2_val),
        .rd_idx  (rd_idx),
        .rd_val  (rd_val),
        .rd_wen  (rd_wen)
    );

    // Decode, operand read and bypass
    letc_core_stage_d stage_d (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_val     (rs1_val),
        .rs2_val     (rs2_val),
        .e_result    (e_result),
        .e_to_w      (e_to_w),
        .d_to_e      (d_to_e)
    );

    // ALU, combinational
    letc_core_stage_e stage_e (
        .d_to_e   (d_to_e),
        .e_result (e_result)
    );

    letc_core_stage_w stage_w (
        .clk      (clk),
        .reset    (reset),
        .e_result (e_result),
        .e_to_w   (e_to_w),
        .rd_idx   (rd_idx),
        .rd_val   (rd_val),
        .rd_wen   (rd_wen),
        .retire   (retire)
    );

endmodule : letc_core_top

`default_nettype wire

/* tests/letc_core_props.sv */
`timescale 1ns/1ps
`default_nettype none

module letc_core_props (
    input logic                    clk,
    input logic                    reset,
    input letc_core_pkg::retire_s  retire,
    input logic                    rd_wen,
    input letc_core_pkg::reg_idx_t rd_idx
);

    // With a synchronous reset the edge after a reset cycle shows it
    no_retire_in_reset: assert property (@(posedge clk) reset |=> !retire.valid)
        else $error("retire during reset");

    // Illegal words never touch the RF
    illegal_no_write: assert property (@(posedge clk) disable iff (reset)
        (retire.valid && retire.illegal) |-> !rd_wen)
        else $error("illegal retire with register write");

    // x0 stays hardwired
    no_x0_write: assert property (@(posedge clk) disable iff (reset)
        rd_wen |-> (rd_idx != '0))
        else $error("write to x0");

endmodule : letc_core_props

bind letc_core_top letc_core_props i_letc_core_props (
    .clk    (clk),
    .reset  (reset),
    .retire (retire),
    .rd_wen (rd_wen),
    .rd_idx (rd_idx)
);

`default_nettype wire

/* tests/letc_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "letc_core_params.svh"

module letc_core_tb;
    import letc_core_pkg::*;

    // Table entry kinds
    localparam logic [1:0] K_OP   = 2'd0;
    localparam logic [1:0] K_IMM  = 2'd1;
    localparam logic [1:0] K_LUI  = 2'd2;
    localparam logic [1:0] K_LOAD = 2'd3;

    typedef struct packed {
        logic [1:0]  kind;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  funct3;
        logic        alt;
        logic [19:0] imm;
        // Random immediate and random idle gap before issue
        logic        rnd_imm;
        logic        rnd_gap;
    } entry_s;

    // One instruction in flight and the cycle its retire is due
    typedef struct packed {
        logic        illegal;
        reg_idx_t    rd;
        word_t       value;
        logic [31:0] due;
    } expect_s;

    logic        clk;
    logic        reset;
    logic        instr_valid;
    instr_t      instr;
    retire_s     retire;

    // Architectural model, updated in issue order
    word_t       ref_regs [0:31];
    expect_s     pending [$];
    entry_s      tbl [$];
    int unsigned cycle;
    int          errors;
    int          timeouts;

    always #50 clk = ~clk;

    letc_core_top i_letc_core_top (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .retire      (retire)
    );

    function automatic instr_t encode(input entry_s e);
        logic [11:0] imm12;
        imm12 = e.imm[11:0];
        // Shifts carry shamt plus the bit 30 selector
        if (e.funct3 == 3'b001 || e.funct3 == 3'b101) begin
            imm12 = {1'b0, e.alt, 5'b0, e.imm[4:0]};
        end
        case (e.kind)
            K_OP: return {1'b0, e.alt, 5'b0, e.rs2, e.rs1, e.funct3, e.rd, `LETC_CORE_OPCODE_OP};
            K_IMM: return {imm12, e.rs1, e.funct3, e.rd, `LETC_CORE_OPCODE_OP_IMM};
            K_LUI: return {e.imm, e.rd, `LETC_CORE_OPCODE_LUI};
            // LW opcode, not handled by this core
            default: return {imm12, e.rs1, 3'b010, e.rd, 7'b0000011};
        endcase
    endfunction

    // RV32I result from the model registers
    function automatic word_t predict(input entry_s e);
        word_t a;
        word_t b;
        a = ref_regs[e.rs1];
        b = (e.kind == K_OP) ? ref_regs[e.rs2] : {{20{e.imm[11]}}, e.imm[11:0]};
        if (e.kind == K_LUI) begin
            return {e.imm, 12'b0};
        end
        case (e.funct3)
            3'b000: return (e.kind == K_OP && e.alt) ? a - b : a + b;
            3'b001: return a << b[4:0];
            3'b010: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011: return (a < b) ? 32'd1 : 32'd0;
            3'b100: return a ^ b;
            3'b101: begin
                // Sign fill for sra
                if (e.alt) begin
                    return $signed(a) >>> b[4:0];
                end
                return a >> b[4:0];
            end
            3'b110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic add_entry(input logic [1:0] kind, input int rd, input int rs1,
                             input int rs2, input int f3, input int alt, input int imm,
                             input int rnd_imm, input int rnd_gap);
        entry_s e;
        e.kind    = kind;
        e.rd      = reg_idx_t'(rd);
        e.rs1     = reg_idx_t'(rs1);
        e.rs2     = reg_idx_t'(rs2);
        e.funct3  = 3'(f3);
        e.alt     = (alt != 0);
        e.imm     = 20'(imm);
        e.rnd_imm = (rnd_imm != 0);
        e.rnd_gap = (rnd_gap != 0);
        tbl.push_back(e);
    endtask

    task automatic build_table();
        // Every register reads zero after reset
        for (int i = 1; i < 32; i++) begin
            add_entry(K_IMM, i, i, 0, 0, 0, 0, 0, 0);
        end
        // Operand setup with x1 negative
        add_entry(K_LUI, 1, 0, 0, 0, 0, 'hfffff, 0, 1);
        add_entry(K_IMM, 1, 1, 0, 0, 0, 'h123, 0, 1);
        add_entry(K_IMM, 2, 0, 0, 0, 0, 'h7ff, 0, 1);
        add_entry(K_LUI, 3, 0, 0, 0, 0, 0, 1, 1);
        add_entry(K_IMM, 3, 3, 0, 0, 0, 0, 1, 1);
        // Register-register ops
        add_entry(K_OP, 4, 1, 2, 0, 0, 0, 0, 1);
        add_entry(K_OP, 5, 2, 1, 0, 1, 0, 0, 0);
        add_entry(K_OP, 6, 2, 3, 1, 0, 0, 0, 1);
        add_entry(K_OP, 7, 1, 2, 2, 0, 0, 0, 0);
        add_entry(K_OP, 8, 1, 2, 3, 0, 0, 0, 1);
        add_entry(K_OP, 9, 1, 3, 4, 0, 0, 0, 0);
        add_entry(K_OP, 10, 1, 3, 5, 0, 0, 0, 1);
        add_entry(K_OP, 11, 1, 3, 5, 1, 0, 0, 0);
        add_entry(K_OP, 12, 2, 3, 6, 0, 0, 0, 1);
        add_entry(K_OP, 13, 1, 3, 7, 0, 0, 0, 0);
        // Register-immediate ops with -1 for slti
        add_entry(K_IMM, 14, 1, 0, 2, 0, 'hfff, 0, 1);
        add_entry(K_IMM, 15, 2, 0, 3, 0, 0, 1, 0);
        add_entry(K_IMM, 16, 1, 0, 4, 0, 0, 1, 1);
        add_entry(K_IMM, 17, 3, 0, 6, 0, 0, 1, 0);
        add_entry(K_IMM, 18, 1, 0, 7, 0, 0, 1, 1);
        add_entry(K_IMM, 19, 1, 0, 1, 0, 4, 0, 0);
        add_entry(K_IMM, 20, 1, 0, 5, 0, 8, 0, 1);
        add_entry(K_IMM, 21, 1, 0, 5, 1, 8, 0, 0);
        // Dependence chain at distances 1, 2 and 3
        add_entry(K_IMM, 22, 2, 0, 0, 0, 1, 0, 1);
        add_entry(K_IMM, 23, 22, 0, 0, 0, 3, 0, 0);
        add_entry(K_OP, 24, 22, 23, 0, 0, 0, 0, 0);
        add_entry(K_OP, 25, 22, 24, 4, 0, 0, 0, 0);
        add_entry(K_OP, 26, 23, 25, 0, 1, 0, 0, 0);
        // Two writes in flight where the younger one wins
        add_entry(K_IMM, 28, 0, 0, 0, 0, 1, 0, 0);
        add_entry(K_IMM, 28, 0, 0, 0, 0, 2, 0, 0);
        add_entry(K_OP, 29, 28, 28, 0, 0, 0, 0, 0);
        // x0 write retires but never sticks
        add_entry(K_OP, 0, 2, 2, 0, 0, 0, 0, 1);
        add_entry(K_OP, 30, 0, 2, 0, 0, 0, 0, 0);
        add_entry(K_IMM, 31, 0, 0, 0, 0, 0, 0, 1);
        // Illegal load keeps old x5
        add_entry(K_IMM, 5, 0, 0, 0, 0, 77, 0, 1);
        add_entry(K_LOAD, 5, 0, 0, 0, 0, 0, 0, 0);
        add_entry(K_IMM, 6, 5, 0, 0, 0, 0, 0, 0);
    endtask

    task automatic check_retire();
        expect_s exp;
        if (retire.valid === 1'b1) begin
            if (pending.size() == 0) begin
                $display("Unexpected retire at %0t with nothing in flight", $time);
                errors++;
            end else begin
                exp = pending.pop_front();
                if (exp.due != cycle) begin
                    $display("CHECK FAILED at %0t: retire due in cycle %0d", $time, exp.due);
                    errors++;
                end
                if (retire.illegal !== exp.illegal || retire.rd_idx !== exp.rd) begin
                    $display("CHECK FAILED at %0t: rd %0d illegal %0b, expected rd %0d illegal %0b",
                             $time, retire.rd_idx, retire.illegal, exp.rd, exp.illegal);
                    errors++;
                end
                if (!exp.illegal && retire.value !== exp.value) begin
                    $display("CHECK FAILED at %0t: x%0d value %h, expected %h",
                             $time, exp.rd, retire.value, exp.value);
                    errors++;
                end
            end
        end else if (pending.size() != 0 && pending[0].due == cycle) begin
            $display("Missing retire at %0t for x%0d", $time, pending[0].rd);
            errors++;
        end
    endtask

    // Check outputs on the falling edge before driving
    task automatic next_cycle();
        @(negedge clk);
        cycle++;
        check_retire();
    endtask

    task automatic issue(input entry_s e);
        expect_s exp;
        instr_valid = 1'b1;
        instr       = encode(e);
        exp.illegal = (e.kind == K_LOAD);
        exp.rd      = e.rd;
        exp.value   = predict(e);
        // Sampled next edge and retired after two more edges
        exp.due     = cycle + 3;
        pending.push_back(exp);
        if (e.kind != K_LOAD && e.rd != '0) begin
            ref_regs[e.rd] = exp.value;
        end
    endtask

    initial begin
        entry_s e;
        int     gap;
        int     waited;
        clk         = 1'b0;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        errors      = 0;
        timeouts    = 0;
        cycle       = 0;
        void'($urandom(32'hbd40));
        foreach (ref_regs[i]) begin
            ref_regs[i] = '0;
        end
        build_table();
        // Retire must stay quiet through reset
        repeat (16) begin
            next_cycle();
        end
        reset = 1'b0;
        foreach (tbl[i]) begin
            e = tbl[i];
            if (e.rnd_imm) begin
                e.imm = 20'($urandom);
            end
            gap = e.rnd_gap ? $urandom_range(3, 0) : 0;
            for (int g = 0; g < gap; g++) begin
                next_cycle();
                instr_valid = 1'b0;
                // Junk on the bus while idle
                instr       = $urandom;
            end
            next_cycle();
            issue(e);
        end
        next_cycle();
        instr_valid = 1'b0;
        // Drain with a bound
        waited = 0;
        while (pending.size() != 0 && waited < 20) begin
            next_cycle();
            waited++;
        end
        if (pending.size() != 0) begin
            $display("Timeout: %0d instructions never retired", pending.size());
            timeouts++;
        end
        $display("Errors: %0d check, %0d timeout", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule : letc_core_tb

`default_nettype wire

/* sources.f */
+incdir+hw
hw/letc_core_pkg.sv
hw/letc_core_rf.sv
hw/letc_core_stage_d.sv
hw/letc_core_stage_e.sv
hw/letc_core_stage_w.sv
hw/letc_core_top.sv
tests/letc_core_props.sv
tests/letc_core_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module letc_core_tb -o letc_core_sim

out=$(./obj_dir/letc_core_sim)
echo "$out"

if echo "$out" | grep -qx "Test passed"; then
    exit 0
else
    exit 1
fi
